//--- src/cart_pkg.sv
package cart_pkg;

    // Console bus widths
    localparam int cpu_addr_w = 16;
    localparam int ppu_addr_w = 14;
    localparam int data_w = 8;

    // Mapper slots
    localparam int map_cnt = 3;

    typedef logic [1:0] slot_t;

    localparam slot_t slot_launcher = 2'd0;
    localparam slot_t slot_nrom = 2'd1;
    localparam slot_t slot_uxrom = 2'd2;

    // CPU fetch of the reset vector low byte
    localparam logic [cpu_addr_w-1:0] reset_vector = 16'hFFFC;

    // High address bits forced to one for WRAM, a 128 KB window at the top
    localparam int wram_top_bits = 6;

endpackage

//--- src/cfg_pkg.sv
package cfg_pkg;

    // Register address carried with each configuration word
    localparam int reg_addr_w = 4;

    localparam logic [reg_addr_w-1:0] reg_mapper = 4'd0;
    localparam logic [reg_addr_w-1:0] reg_launcher = 4'd1;

    // Mapper select word
    typedef struct packed {
        logic [1:0] map_args;
        logic [4:0] size_log2;
        logic [4:0] slot;
    } mapper_cfg_t;

    // Launcher control word
    typedef struct packed {
        logic [9:0] pad;
        logic halt;
        logic buffer_num;
    } launcher_cfg_t;

    // One 12-bit word, read as either layout depending on the register address
    typedef union packed {
        mapper_cfg_t mapper;
        launcher_cfg_t launcher;
    } cfg_word_u;

endpackage

//--- src/map_bus.sv
`timescale 1ns/1ns

interface map_bus #(
    parameter int addr_bits = 23
) (
    input logic clk
);
    // Decoded console bus towards the mapper
    logic reset;
    logic m2_fall;
    logic [cart_pkg::cpu_addr_w-1:0] cpu_addr;
    logic [cart_pkg::data_w-1:0] cpu_data_in;
    logic cpu_rw;
    logic [cart_pkg::ppu_addr_w-1:0] ppu_addr;
    logic mirroring;

    // Flat memory addresses and strobes from the mapper
    logic [addr_bits-1:0] prg_addr;
    logic prg_oe;
    logic prg_we;
    logic wram_ce;
    logic [addr_bits-1:0] chr_addr;
    logic chr_ce;
    logic chr_oe;
    logic chr_we;
    logic ciram_a10;
    logic ciram_ce;
    logic [cart_pkg::data_w-1:0] cpu_data_out;
    logic custom_cpu_out;

    modport host (
        input clk,
        output reset, m2_fall, cpu_addr, cpu_data_in, cpu_rw, ppu_addr, mirroring,
        input prg_addr, prg_oe, prg_we, wram_ce, chr_addr, chr_ce, chr_oe, chr_we,
        input ciram_a10, ciram_ce, cpu_data_out, custom_cpu_out
    );

    modport mapper (
        input clk,
        input reset, m2_fall, cpu_addr, cpu_data_in, cpu_rw, ppu_addr, mirroring,
        output prg_addr, prg_oe, prg_we, wram_ce, chr_addr, chr_ce, chr_oe, chr_we,
        output ciram_a10, ciram_ce, cpu_data_out, custom_cpu_out
    );

endinterface

//--- src/map_ctrl.sv
`timescale 1ns/1ns

module map_ctrl (
    input  logic clk,
    input  logic cpu_reset,
    input  logic m2,
    input  logic [cart_pkg::cpu_addr_w-1:0] cpu_addr,
    input  logic cpu_rw,
    input  cfg_pkg::cfg_word_u wr_reg,
    input  logic [cfg_pkg::reg_addr_w-1:0] wr_reg_addr,
    input  logic wr_reg_changed,
    output logic m2_fall,
    output cart_pkg::slot_t select,
    output logic [cart_pkg::map_cnt-1:0] slot_reset,
    output logic [4:0] size_log2,
    output logic mirroring,
    output logic video_enable,
    output logic refresh,
    output logic [31:0] status
);
    cfg_pkg::mapper_cfg_t pending_cfg;
    cart_pkg::slot_t pending_slot;
    cart_pkg::slot_t select_reg;
    logic [4:0] size_reg;
    logic mirror_reg;
    logic load_pending;
    logic switching;
    logic [1:0] m2_sync;
    logic m2_last;
    logic [2:0] wr_sync;
    logic wr_event;
    logic [1:0] launcher_word;

    // Unknown slot numbers fall back to the launcher
    assign pending_slot = (pending_cfg.slot < cart_pkg::map_cnt) ?
                          cart_pkg::slot_t'(pending_cfg.slot) : cart_pkg::slot_launcher;

    // The new mapper already answers the reset vector fetch itself
    assign switching = load_pending && m2 && cpu_rw && (cpu_addr == cart_pkg::reset_vector);

    assign select = switching ? pending_slot : select_reg;
    assign size_log2 = switching ? pending_cfg.size_log2 : size_reg;
    assign mirroring = switching ? pending_cfg.map_args[0] : mirror_reg;

    always_comb begin
        for (int n = 0; n < cart_pkg::map_cnt; n++) begin
            slot_reset[n] = cpu_reset || (select != cart_pkg::slot_t'(n));
        end
    end

    assign wr_event = wr_sync[2] != wr_sync[1];

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            m2_sync <= '0;
            m2_last <= 1'b0;
            m2_fall <= 1'b0;
            wr_sync <= {3{wr_reg_changed}};
        end else begin
            m2_sync <= {m2_sync[0], m2};
            m2_last <= m2_sync[1];
            m2_fall <= m2_last && !m2_sync[1];
            wr_sync <= {wr_sync[1:0], wr_reg_changed};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_event && wr_reg_addr == cfg_pkg::reg_mapper) begin
            pending_cfg <= wr_reg.mapper;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            select_reg <= cart_pkg::slot_launcher;
            size_reg <= '0;
            mirror_reg <= 1'b0;
            load_pending <= 1'b0;
            launcher_word <= '0;
            video_enable <= 1'b0;
        end else begin
            if (wr_event && wr_reg_addr == cfg_pkg::reg_mapper) begin
                load_pending <= 1'b1;
            end else if (wr_event && wr_reg_addr == cfg_pkg::reg_launcher) begin
                launcher_word <= {wr_reg.launcher.halt, wr_reg.launcher.buffer_num};
                video_enable <= !wr_reg.launcher.halt;
            end

            if (switching) begin
                select_reg <= pending_slot;
                size_reg <= pending_cfg.size_log2;
                mirror_reg <= pending_cfg.map_args[0];
                load_pending <= 1'b0;
            end
        end
    end

    // Refresh runs once the CPU access has finished
    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            refresh <= 1'b0;
            status <= '0;
        end else begin
            refresh <= m2_fall && (select_reg != cart_pkg::slot_launcher);
            if (m2_fall) begin
                status <= {29'd0, load_pending, launcher_word};
            end
        end
    end

endmodule

//--- src/mapper_nrom.sv
`timescale 1ns/1ns

module mapper_nrom #(
    parameter int addr_bits = 23
) (
    map_bus.mapper bus
);
    logic prg_sel;
    logic wram_sel;
    logic chr_sel;

    assign prg_sel = bus.cpu_addr[15];
    assign wram_sel = bus.cpu_addr[15:13] == 3'b011;
    assign chr_sel = !bus.ppu_addr[13];

    // 32 KB ROM at 0x8000, 8 KB WRAM at 0x6000
    assign bus.prg_addr = wram_sel ? addr_bits'(bus.cpu_addr[12:0]) :
                                     addr_bits'(bus.cpu_addr[14:0]);
    assign bus.prg_oe = (prg_sel || wram_sel) && bus.cpu_rw;
    assign bus.prg_we = wram_sel && !bus.cpu_rw;
    assign bus.wram_ce = wram_sel;

    assign bus.chr_addr = addr_bits'(bus.ppu_addr[12:0]);
    assign bus.chr_ce = chr_sel;
    assign bus.chr_oe = chr_sel;
    assign bus.chr_we = chr_sel;

    // Nametables in console RAM
    assign bus.ciram_ce = bus.ppu_addr[13];
    assign bus.ciram_a10 = bus.mirroring ? bus.ppu_addr[10] : bus.ppu_addr[11];

    assign bus.cpu_data_out = '0;
    assign bus.custom_cpu_out = 1'b0;

endmodule

//--- src/mapper_uxrom.sv
`timescale 1ns/1ns

module mapper_uxrom #(
    parameter int addr_bits = 23
) (
    map_bus.mapper bus
);
    localparam logic [cart_pkg::cpu_addr_w-1:0] bank_rd_addr = 16'h5000;

    logic [3:0] bank;
    logic [3:0] bank_field;
    logic prg_sel;
    logic wram_sel;
    logic reg_rd;
    logic chr_sel;

    // Bank select by any write to ROM space
    always_ff @(posedge bus.clk) begin
        if (bus.reset) begin
            bank <= '0;
        end else if (bus.m2_fall && !bus.cpu_rw && bus.cpu_addr[15]) begin
            bank <= bus.cpu_data_in[3:0];
        end
    end

    assign prg_sel = bus.cpu_addr[15];
    assign wram_sel = bus.cpu_addr[15:13] == 3'b011;
    assign reg_rd = (bus.cpu_addr == bank_rd_addr) && bus.cpu_rw;
    assign chr_sel = !bus.ppu_addr[13];

    // Upper half pinned to all ones, the size mask turns it into the last bank
    assign bank_field = bus.cpu_addr[14] ? 4'hF : bank;

    assign bus.prg_addr = wram_sel ? addr_bits'(bus.cpu_addr[12:0]) :
                                     addr_bits'({bank_field, bus.cpu_addr[13:0]});
    assign bus.prg_oe = (prg_sel || wram_sel || reg_rd) && bus.cpu_rw;
    assign bus.prg_we = wram_sel && !bus.cpu_rw;
    assign bus.wram_ce = wram_sel;

    assign bus.chr_addr = addr_bits'(bus.ppu_addr[12:0]);
    assign bus.chr_ce = chr_sel;
    assign bus.chr_oe = chr_sel;
    assign bus.chr_we = chr_sel;

    assign bus.ciram_ce = bus.ppu_addr[13];
    assign bus.ciram_a10 = bus.mirroring ? bus.ppu_addr[10] : bus.ppu_addr[11];

    // Bank readback for the menu
    assign bus.cpu_data_out = {4'd0, bank};
    assign bus.custom_cpu_out = reg_rd;

endmodule

//--- src/mapper_mux.sv
`timescale 1ns/1ns

module mapper_mux #(
    parameter int addr_bits = 23
) (
    map_bus.host buses [cart_pkg::map_cnt],
    input  cart_pkg::slot_t select,
    input  logic [4:0] size_log2,
    input  logic video_enable,
    input  logic m2,
    input  logic [cart_pkg::data_w-1:0] ppu_data_in,
    output logic [addr_bits-1:0] prg_addr,
    output logic prg_oe,
    output logic prg_we,
    output logic [addr_bits-1:0] chr_addr,
    output logic chr_oe,
    output logic chr_we,
    output logic ciram_a10,
    output logic ciram_ce,
    output logic cpu_oe,
    output logic [cart_pkg::data_w-1:0] cpu_data_out,
    output logic ppu_oe,
    output logic [cart_pkg::data_w-1:0] ppu_data_out
);
    localparam logic [addr_bits-1:0] wram_mask =
        {{cart_pkg::wram_top_bits{1'b1}}, {(addr_bits - cart_pkg::wram_top_bits){1'b0}}};

    logic [addr_bits-1:0] bus_prg_addr [cart_pkg::map_cnt];
    logic bus_prg_oe [cart_pkg::map_cnt];
    logic bus_prg_we [cart_pkg::map_cnt];
    logic bus_wram_ce [cart_pkg::map_cnt];
    logic [addr_bits-1:0] bus_chr_addr [cart_pkg::map_cnt];
    logic bus_chr_ce [cart_pkg::map_cnt];
    logic bus_chr_oe [cart_pkg::map_cnt];
    logic bus_chr_we [cart_pkg::map_cnt];
    logic bus_ciram_a10 [cart_pkg::map_cnt];
    logic bus_ciram_ce [cart_pkg::map_cnt];
    logic [cart_pkg::data_w-1:0] bus_cpu_data_out [cart_pkg::map_cnt];
    logic bus_custom_cpu_out [cart_pkg::map_cnt];

    logic [addr_bits-1:0] prg_mask;
    logic [addr_bits-1:0] chr_offset;

    // Per-slot copies of the mapper outputs
    for (genvar n = 0; n < cart_pkg::map_cnt; n++) begin : g_unpack
        assign bus_prg_addr[n] = buses[n].prg_addr;
        assign bus_prg_oe[n] = buses[n].prg_oe;
        assign bus_prg_we[n] = buses[n].prg_we;
        assign bus_wram_ce[n] = buses[n].wram_ce;
        assign bus_chr_addr[n] = buses[n].chr_addr;
        assign bus_chr_ce[n] = buses[n].chr_ce;
        assign bus_chr_oe[n] = buses[n].chr_oe;
        assign bus_chr_we[n] = buses[n].chr_we;
        assign bus_ciram_a10[n] = buses[n].ciram_a10;
        assign bus_ciram_ce[n] = buses[n].ciram_ce;
        assign bus_cpu_data_out[n] = buses[n].cpu_data_out;
        assign bus_custom_cpu_out[n] = buses[n].custom_cpu_out;
    end

    assign prg_mask = addr_bits'((32'd1 << size_log2) - 32'd1);
    assign chr_offset = (size_log2 == '0) ? '0 : addr_bits'(32'd1 << size_log2);

    assign prg_addr = bus_wram_ce[select] ? (bus_prg_addr[select] | wram_mask) :
                                            (bus_prg_addr[select] & prg_mask);

    // Strobes follow m2 so the level shifters turn around with the CPU
    assign prg_oe = bus_prg_oe[select] && m2 && !bus_custom_cpu_out[select];
    assign prg_we = bus_prg_we[select] && m2;
    assign cpu_oe = bus_prg_oe[select] && m2;
    assign cpu_data_out = bus_custom_cpu_out[select] ? bus_cpu_data_out[select] : '0;

    assign chr_addr = bus_chr_addr[select] | chr_offset;
    assign chr_oe = bus_chr_oe[select];
    assign chr_we = bus_chr_we[select];
    assign ciram_a10 = bus_ciram_a10[select];
    assign ciram_ce = bus_ciram_ce[select];

    // Launcher picture stays black until video is enabled
    assign ppu_oe = bus_chr_ce[select] && bus_chr_oe[select];
    assign ppu_data_out = (video_enable || select != cart_pkg::slot_launcher) ?
                          ppu_data_in : '0;

endmodule

//--- src/cart_top.sv
`timescale 1ns/1ns

module cart_top #(
    parameter int addr_bits = 23
) (
    input  logic clk,
    input  logic cpu_reset,
    input  logic m2,
    input  logic [cart_pkg::cpu_addr_w-1:0] cpu_addr,
    input  logic [cart_pkg::data_w-1:0] cpu_data_in,
    input  logic cpu_rw,
    input  logic ppu_rd,
    input  logic ppu_wr,
    input  logic [cart_pkg::ppu_addr_w-1:0] ppu_addr,
    input  logic [cart_pkg::data_w-1:0] ppu_data_in,
    input  logic [$bits(cfg_pkg::cfg_word_u)-1:0] wr_reg,
    input  logic [cfg_pkg::reg_addr_w-1:0] wr_reg_addr,
    input  logic wr_reg_changed,
    output logic [cart_pkg::data_w-1:0] cpu_data_out,
    output logic cpu_oe,
    output logic [cart_pkg::data_w-1:0] ppu_data_out,
    output logic ppu_oe,
    output logic ciram_a10,
    output logic ciram_ce,
    output logic [addr_bits-1:0] prg_addr,
    output logic prg_oe,
    output logic prg_we,
    output logic [addr_bits-1:0] chr_addr,
    output logic chr_oe,
    output logic chr_we,
    output logic refresh,
    output logic [31:0] status
);
    cfg_pkg::cfg_word_u cfg_word;
    cart_pkg::slot_t select;
    logic [cart_pkg::map_cnt-1:0] slot_reset;
    logic [4:0] size_log2;
    logic m2_fall;
    logic mirroring;
    logic video_enable;
    logic mux_chr_oe;
    logic mux_chr_we;

    assign cfg_word = wr_reg;

    map_bus #(.addr_bits(addr_bits)) mbus [cart_pkg::map_cnt] (.clk(clk));

    for (genvar n = 0; n < cart_pkg::map_cnt; n++) begin : g_bus
        assign mbus[n].reset = slot_reset[n];
        assign mbus[n].m2_fall = m2_fall;
        assign mbus[n].cpu_addr = cpu_addr;
        assign mbus[n].cpu_data_in = cpu_data_in;
        assign mbus[n].cpu_rw = cpu_rw;
        assign mbus[n].ppu_addr = ppu_addr;
        assign mbus[n].mirroring = mirroring;
    end

    map_ctrl u_ctrl (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .m2(m2),
        .cpu_addr(cpu_addr),
        .cpu_rw(cpu_rw),
        .wr_reg(cfg_word),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .m2_fall(m2_fall),
        .select(select),
        .slot_reset(slot_reset),
        .size_log2(size_log2),
        .mirroring(mirroring),
        .video_enable(video_enable),
        .refresh(refresh),
        .status(status)
    );

    mapper_nrom #(.addr_bits(addr_bits)) u_launcher (.bus(mbus[cart_pkg::slot_launcher]));
    mapper_nrom #(.addr_bits(addr_bits)) u_nrom (.bus(mbus[cart_pkg::slot_nrom]));
    mapper_uxrom #(.addr_bits(addr_bits)) u_uxrom (.bus(mbus[cart_pkg::slot_uxrom]));

    mapper_mux #(.addr_bits(addr_bits)) u_mux (
        .buses(mbus),
        .select(select),
        .size_log2(size_log2),
        .video_enable(video_enable),
        .m2(m2),
        .ppu_data_in(ppu_data_in),
        .prg_addr(prg_addr),
        .prg_oe(prg_oe),
        .prg_we(prg_we),
        .chr_addr(chr_addr),
        .chr_oe(mux_chr_oe),
        .chr_we(mux_chr_we),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce),
        .cpu_oe(cpu_oe),
        .cpu_data_out(cpu_data_out),
        .ppu_oe(ppu_oe),
        .ppu_data_out(ppu_data_out)
    );

    // CHR memory strobes qualified by the PPU read and write lines
    assign chr_oe = mux_chr_oe && ppu_rd;
    assign chr_we = mux_chr_we && ppu_wr;

endmodule

//--- test/cart_tb.sv
`timescale 1ns/1ns

module cart_tb;
    localparam int addr_bits = 23;

    // Upper bounds of the stimulus below
    localparam int sched_cpu_cycles = 70;
    localparam int sched_cfg_writes = 3;
    localparam int sched_ppu_accesses = 48;
    localparam int sched_clocks = 4 + sched_cpu_cycles * 12 + sched_cfg_writes * 5 +
                                  sched_ppu_accesses;
    localparam int cycle_limit = 4 * sched_clocks;

    logic clk;
    logic cpu_reset;
    logic m2;
    logic [15:0] cpu_addr;
    logic [7:0] cpu_data_in;
    logic cpu_rw;
    logic ppu_rd;
    logic ppu_wr;
    logic [13:0] ppu_addr;
    logic [7:0] ppu_data_in;
    logic [11:0] wr_reg;
    logic [3:0] wr_reg_addr;
    logic wr_reg_changed;
    logic [7:0] cpu_data_out;
    logic cpu_oe;
    logic [7:0] ppu_data_out;
    logic ppu_oe;
    logic ciram_a10;
    logic ciram_ce;
    logic [addr_bits-1:0] prg_addr;
    logic prg_oe;
    logic prg_we;
    logic [addr_bits-1:0] chr_addr;
    logic chr_oe;
    logic chr_we;
    logic refresh;
    logic [31:0] status;

    logic [31:0] lfsr;
    int value_errors;
    int strobe_errors;
    int refresh_count;
    int cycle_count;

    // Reference model state
    logic [1:0] model_slot;
    logic [4:0] model_size;
    logic model_mirror;
    logic [3:0] model_bank;
    logic model_pending;
    cfg_pkg::mapper_cfg_t model_pend;
    logic [1:0] model_launcher;
    logic model_video;

    cart_top #(.addr_bits(addr_bits)) dut (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .m2(m2),
        .cpu_addr(cpu_addr),
        .cpu_data_in(cpu_data_in),
        .cpu_rw(cpu_rw),
        .ppu_rd(ppu_rd),
        .ppu_wr(ppu_wr),
        .ppu_addr(ppu_addr),
        .ppu_data_in(ppu_data_in),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .cpu_data_out(cpu_data_out),
        .cpu_oe(cpu_oe),
        .ppu_data_out(ppu_data_out),
        .ppu_oe(ppu_oe),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce),
        .prg_addr(prg_addr),
        .prg_oe(prg_oe),
        .prg_we(prg_we),
        .chr_addr(chr_addr),
        .chr_oe(chr_oe),
        .chr_we(chr_we),
        .refresh(refresh),
        .status(status)
    );

    always #10 clk = !clk;

    always @(negedge clk) begin
        if (refresh) begin
            refresh_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d clocks, the stimulus never finished", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // CPU side strobes only while m2 is high
    strobes_idle: assert property (@(posedge clk) disable iff (cpu_reset)
        !m2 |-> (!prg_we && !prg_oe && !cpu_oe))
    else begin
        strobe_errors++;
        $display("A PRG or CPU strobe was high while m2 was low at %0t", $time);
    end

    refresh_single: assert property (@(posedge clk) disable iff (cpu_reset)
        refresh |=> !refresh)
    else begin
        strobe_errors++;
        $display("refresh stayed high for more than one clock at %0t", $time);
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [addr_bits-1:0] exp_prg(input logic [15:0] a);
        logic [3:0] field;
        logic [addr_bits-1:0] base;
        logic [addr_bits-1:0] mask;
        mask = addr_bits'((32'd1 << model_size) - 32'd1);
        if (a[15:13] == 3'b011) begin
            return addr_bits'({6'h3F, 4'd0, a[12:0]});
        end
        field = a[14] ? 4'hF : model_bank;
        if (model_slot == cart_pkg::slot_uxrom) begin
            base = addr_bits'({field, a[13:0]});
        end else begin
            base = addr_bits'(a[14:0]);
        end
        return base & mask;
    endfunction

    function automatic logic [addr_bits-1:0] exp_chr(input logic [13:0] pa);
        logic [addr_bits-1:0] offset;
        offset = (model_size == 5'd0) ? '0 : addr_bits'(32'd1 << model_size);
        return addr_bits'(pa[12:0]) | offset;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            value_errors++;
            $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic write_cfg(input logic [3:0] reg_addr, input cfg_pkg::cfg_word_u w);
        @(negedge clk);
        wr_reg = w;
        wr_reg_addr = reg_addr;
        wr_reg_changed = !wr_reg_changed;
        repeat (4) @(negedge clk);
        if (reg_addr == cfg_pkg::reg_mapper) begin
            model_pending = 1'b1;
            model_pend = w.mapper;
        end else if (reg_addr == cfg_pkg::reg_launcher) begin
            model_launcher = {w.launcher.halt, w.launcher.buffer_num};
            model_video = !w.launcher.halt;
        end
    endtask

    // One CPU cycle, m2 high for 6 clocks then low for 6
    task automatic cpu_cycle(input logic [15:0] a, input logic rw, input logic [7:0] d);
        logic wram;
        logic [1:0] new_slot;
        int refresh_start;
        wram = (a[15:13] == 3'b011);
        @(negedge clk);
        cpu_addr = a;
        cpu_rw = rw;
        cpu_data_in = d;
        m2 = 1'b1;
        if (model_pending && rw && a == 16'hFFFC) begin
            new_slot = (model_pend.slot < 5'd3) ? model_pend.slot[1:0] : 2'd0;
            if (new_slot != model_slot) begin
                model_bank = 4'd0;
            end
            model_slot = new_slot;
            model_size = model_pend.size_log2;
            model_mirror = model_pend.map_args[0];
            model_pending = 1'b0;
        end
        #5;
        refresh_start = refresh_count;
        if ((rw && a[15]) || wram) begin
            check_value("prg_addr", 32'(exp_prg(a)), 32'(prg_addr));
        end
        if (rw && (a[15] || wram)) begin
            check_value("prg_oe", 32'(1), 32'(prg_oe));
            check_value("cpu_oe", 32'(1), 32'(cpu_oe));
        end
        if (!rw) begin
            check_value("prg_oe", 32'(0), 32'(prg_oe));
            check_value("cpu_oe", 32'(0), 32'(cpu_oe));
        end
        if (wram) begin
            check_value("prg_we", 32'(!rw), 32'(prg_we));
        end else begin
            check_value("prg_we", 32'(0), 32'(prg_we));
        end
        if (rw && a == 16'h5000 && model_slot == cart_pkg::slot_uxrom) begin
            check_value("cpu_data_out", 32'(model_bank), 32'(cpu_data_out));
            check_value("cpu_oe", 32'(1), 32'(cpu_oe));
            check_value("prg_oe", 32'(0), 32'(prg_oe));
        end
        repeat (6) @(negedge clk);
        m2 = 1'b0;
        if (model_slot == cart_pkg::slot_uxrom && !rw && a[15]) begin
            model_bank = d[3:0];
        end
        repeat (5) @(negedge clk);
        #5;
        check_value("refresh_pulses", (model_slot != cart_pkg::slot_launcher) ? 32'd1 : 32'd0,
                    32'(refresh_count - refresh_start));
        check_value("status", {29'd0, model_pending, model_launcher}, status);
    endtask

    task automatic ppu_access(input logic [13:0] pa, input logic [7:0] d);
        logic [7:0] exp_data;
        logic wr;
        @(negedge clk);
        wr = rand_bits(1) != 0;
        ppu_addr = pa;
        ppu_data_in = d;
        ppu_rd = !wr;
        ppu_wr = wr;
        exp_data = (model_slot == cart_pkg::slot_launcher && !model_video) ? 8'd0 : d;
        #5;
        if (!pa[13]) begin
            check_value("chr_addr", 32'(exp_chr(pa)), 32'(chr_addr));
            check_value("ppu_oe", 32'(1), 32'(ppu_oe));
            check_value("chr_oe", 32'(!wr), 32'(chr_oe));
            check_value("chr_we", 32'(wr), 32'(chr_we));
            check_value("ciram_ce", 32'(0), 32'(ciram_ce));
            check_value("ppu_data_out", 32'(exp_data), 32'(ppu_data_out));
        end else begin
            check_value("ciram_ce", 32'(1), 32'(ciram_ce));
            check_value("ciram_a10", 32'(model_mirror ? pa[10] : pa[11]), 32'(ciram_a10));
            check_value("ppu_oe", 32'(0), 32'(ppu_oe));
            check_value("chr_oe", 32'(0), 32'(chr_oe));
            check_value("chr_we", 32'(0), 32'(chr_we));
        end
    endtask

    initial begin
        cfg_pkg::cfg_word_u w;
        logic [15:0] a;
        clk = 1'b0;
        cpu_reset = 1'b1;
        m2 = 1'b0;
        cpu_addr = '0;
        cpu_data_in = '0;
        cpu_rw = 1'b1;
        ppu_rd = 1'b0;
        ppu_wr = 1'b0;
        ppu_addr = '0;
        ppu_data_in = '0;
        wr_reg = '0;
        wr_reg_addr = '0;
        wr_reg_changed = 1'b0;
        lfsr = 32'h903c;
        value_errors = 0;
        strobe_errors = 0;
        refresh_count = 0;
        cycle_count = 0;
        model_slot = cart_pkg::slot_launcher;
        model_size = '0;
        model_mirror = 1'b0;
        model_bank = '0;
        model_pending = 1'b0;
        model_pend = '0;
        model_launcher = '0;
        model_video = 1'b0;
        repeat (3) @(negedge clk);
        cpu_reset = 1'b0;

        // Launcher after reset, video blanked
        repeat (8) begin
            a = {1'b1, 15'(rand_bits(15))};
            cpu_cycle(a, 1'b1, 8'd0);
        end
        repeat (8) ppu_access(14'(rand_bits(14)), 8'(rand_bits(8)));

        // Launcher word with halt clear
        w = '0;
        w.launcher.halt = 1'b0;
        w.launcher.buffer_num = 1'b1;
        write_cfg(cfg_pkg::reg_launcher, w);
        cpu_cycle({1'b1, 15'(rand_bits(15))}, 1'b1, 8'd0);
        repeat (4) ppu_access({1'b0, 13'(rand_bits(13))}, 8'(rand_bits(8)));

        // Armed switch to UxROM, taken on the reset vector read
        w = '0;
        w.mapper.slot = 5'(cart_pkg::slot_uxrom);
        w.mapper.size_log2 = 5'(15 + rand_bits(3));
        w.mapper.map_args = 2'b00;
        write_cfg(cfg_pkg::reg_mapper, w);
        repeat (4) begin
            a = {1'b1, 15'(rand_bits(15))};
            if (a == 16'hFFFC) begin
                a = 16'hFFF0;
            end
            cpu_cycle(a, 1'b1, 8'd0);
        end
        cpu_cycle(16'hFFFC, 1'b1, 8'd0);

        repeat (3) begin
            cpu_cycle({1'b1, 15'(rand_bits(15))}, 1'b0, 8'(rand_bits(8)));
            repeat (6) cpu_cycle({2'b10, 14'(rand_bits(14))}, 1'b1, 8'd0);
            repeat (4) cpu_cycle({2'b11, 14'(rand_bits(14))}, 1'b1, 8'd0);
            cpu_cycle(16'h5000, 1'b1, 8'd0);
        end

        // WRAM window and CHR offset
        repeat (8) begin
            cpu_cycle({3'b011, 13'(rand_bits(13))}, rand_bits(1) != 0, 8'(rand_bits(8)));
        end
        repeat (8) ppu_access({1'b0, 13'(rand_bits(13))}, 8'(rand_bits(8)));
        repeat (8) ppu_access({1'b1, 13'(rand_bits(13))}, 8'(rand_bits(8)));

        // NROM with vertical mirroring
        w = '0;
        w.mapper.slot = 5'(cart_pkg::slot_nrom);
        w.mapper.size_log2 = 5'(15 + rand_bits(3));
        w.mapper.map_args = 2'b01;
        write_cfg(cfg_pkg::reg_mapper, w);
        cpu_cycle(16'hFFFC, 1'b1, 8'd0);
        repeat (4) cpu_cycle({1'b1, 15'(rand_bits(15))}, 1'b1, 8'd0);
        repeat (8) ppu_access({1'b1, 13'(rand_bits(13))}, 8'(rand_bits(8)));
        repeat (8) ppu_access(14'(rand_bits(14)), 8'(rand_bits(8)));

        $display("Checks done with %0d value errors and %0d strobe errors",
                 value_errors, strobe_errors);
        if (value_errors + strobe_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- build.f
src/cart_pkg.sv
src/cfg_pkg.sv
src/map_bus.sv
src/map_ctrl.sv
src/mapper_nrom.sv
src/mapper_uxrom.sv
src/mapper_mux.sv
src/cart_top.sv
test/cart_tb.sv
